// File: Bender.yml
package:
  name: dadda_multiplier

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/dadda_pkg.sv
      - source/partial_product_array.sv
      - source/dadda_reduction_stage.sv
      - source/dadda_tree.sv
      - source/brent_kung_adder.sv
      - source/dadda_multiplier.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/dadda_multiplier_tb.sv

// File: include/dadda_macros.svh
`ifndef DADDA_MACROS_SVH
`define DADDA_MACROS_SVH

// operand and product widths
`define DADDA_OPERAND_WIDTH 16
`define DADDA_PRODUCT_WIDTH (2 * `DADDA_OPERAND_WIDTH)

// reduction stages for a 16 bit heap, heights 13 9 6 4 3 2
`define DADDA_STAGES 6

// accepted operands to registered product
`define DADDA_LATENCY 2

`endif

// File: source/brent_kung_adder.sv
`timescale 1ns/1ns
`default_nettype none

`include "dadda_macros.svh"

module brent_kung_adder (
  input  wire dadda_pkg::product_t x,
  input  wire dadda_pkg::product_t y,
  output dadda_pkg::product_t      sum
);

  localparam int WIDTH = `DADDA_PRODUCT_WIDTH;
  localparam int UP_LEVELS = $clog2(WIDTH);
  localparam int LEVELS = 2 * UP_LEVELS - 1;

  // group generate and propagate after each tree level
  logic [WIDTH-1:0] gen_l [0:LEVELS];
  logic [WIDTH-1:0] prop_l [0:LEVELS];

  assign gen_l[0] = x & y;
  assign prop_l[0] = x ^ y;

  for (genvar lvl = 1; lvl <= LEVELS; lvl++)
  begin : g_level
    // span doubles on the way up, halves on the way down
    localparam int SPAN = (lvl <= UP_LEVELS) ? (1 << (lvl - 1)) : (1 << (LEVELS - lvl));

    for (genvar i = 0; i < WIDTH; i++)
    begin : g_bit
      // up-sweep merges aligned blocks of 2*SPAN bits
      localparam bit UP_NODE = (lvl <= UP_LEVELS) && ((i + 1) % (2 * SPAN) == 0);
      // down-sweep fills the midpoints the up-sweep skipped
      localparam bit DOWN_NODE = (lvl > UP_LEVELS) && ((i + 1) % (2 * SPAN) == SPAN)
        && (i + 1 > 2 * SPAN);

      if (UP_NODE || DOWN_NODE)
      begin : g_node
        assign gen_l[lvl][i] = gen_l[lvl-1][i] | (prop_l[lvl-1][i] & gen_l[lvl-1][i-SPAN]);
        assign prop_l[lvl][i] = prop_l[lvl-1][i] & prop_l[lvl-1][i-SPAN];
      end
      else
      begin : g_pass
        assign gen_l[lvl][i] = gen_l[lvl-1][i];
        assign prop_l[lvl][i] = prop_l[lvl-1][i];
      end
    end
  end

  // gen_l[LEVELS][i] is the carry into bit i + 1
  // bit 31 would be the carry out, never set for a 16x16 product
  assign sum = prop_l[0] ^ {gen_l[LEVELS][WIDTH-2:0], 1'b0};

endmodule

`default_nettype wire

// File: source/dadda_multiplier.sv
`timescale 1ns/1ns
`default_nettype none

`include "dadda_macros.svh"

module dadda_multiplier (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                in_valid,
  input  wire dadda_pkg::operand_t a,
  input  wire dadda_pkg::operand_t b,
  output logic                     out_valid,
  output dadda_pkg::product_t      product
);

  localparam int WIDTH = `DADDA_PRODUCT_WIDTH;

  dadda_pkg::column_heap_t heap;
  dadda_pkg::product_t     sum_row;
  dadda_pkg::product_t     carry_row;
  dadda_pkg::product_t     sum_row_q;
  dadda_pkg::product_t     carry_row_q;
  dadda_pkg::product_t     adder_sum;
  logic                    rows_valid;
  logic [WIDTH:0]          row_total;

  partial_product_array partial_product_array_i (
    .a    (a),
    .b    (b),
    .heap (heap)
  );

  dadda_tree dadda_tree_i (
    .heap      (heap),
    .sum_row   (sum_row),
    .carry_row (carry_row)
  );

  // stage one, rows out of the tree
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rows_valid <= 1'b0;
    else
      rows_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      sum_row_q <= sum_row;
      carry_row_q <= carry_row;
    end
  end

  brent_kung_adder brent_kung_adder_i (
    .x   (sum_row_q),
    .y   (carry_row_q),
    .sum (adder_sum)
  );

  // stage two, product holds between results
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else
      out_valid <= rows_valid;
  end

  always_ff @(posedge clk)
  begin
    if (rows_valid)
      product <= adder_sum;
  end

  // the full sum of both rows, with room for an overflow bit
  assign row_total = {1'b0, sum_row_q} + {1'b0, carry_row_q};

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == $past(in_valid, `DADDA_LATENCY));

  a_product_known: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(product));

  // a correct tree never hands the adder a sum past 32 bits
  a_rows_fit: assert property (@(posedge clk) disable iff (!rst_n)
    rows_valid |-> !row_total[WIDTH]);

endmodule

`default_nettype wire

// File: source/dadda_pkg.sv
`default_nettype none

`include "dadda_macros.svh"

package dadda_pkg;

  typedef logic [`DADDA_OPERAND_WIDTH-1:0] operand_t;
  typedef logic [`DADDA_PRODUCT_WIDTH-1:0] product_t;

  // one column per product bit, each with room for a full operand's worth of bits
  typedef logic [`DADDA_PRODUCT_WIDTH-1:0][`DADDA_OPERAND_WIDTH-1:0] column_heap_t;

  // dadda sequence d(j+1) = floor(1.5 d(j)) from d = 2, last stage first
  function automatic int stage_target_height(int stage);
    int height;
    height = 2;
    for (int i = stage; i < `DADDA_STAGES - 1; i++)
      height = (height * 3) / 2;
    return height;
  endfunction

  // partial product bits landing in a column
  function automatic int initial_column_height(int column);
    if (column < `DADDA_OPERAND_WIDTH)
      return column + 1;
    else if (column < `DADDA_PRODUCT_WIDTH - 1)
      return `DADDA_PRODUCT_WIDTH - 1 - column;
    else
      return 0;
  endfunction

endpackage

`default_nettype wire

// File: source/dadda_reduction_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "dadda_macros.svh"

module dadda_reduction_stage #(
  parameter int STAGE = 0
) (
  input  wire dadda_pkg::column_heap_t heap_in,
  output dadda_pkg::column_heap_t      heap_out
);

  localparam int COLUMNS = `DADDA_PRODUCT_WIDTH;
  localparam int SLOTS = `DADDA_OPERAND_WIDTH;
  localparam int TARGET = dadda_pkg::stage_target_height(STAGE);

  // replays the stages before this one
  // returns a column's incoming height, or the carries it gets from below
  function automatic int column_state(int stage, int col, bit want_carry);
    int heights [COLUMNS];
    int carries;
    int excess;
    for (int c = 0; c < COLUMNS; c++)
      heights[c] = dadda_pkg::initial_column_height(c);
    for (int s = 0; s <= stage; s++)
    begin
      carries = 0;
      for (int c = 0; c < COLUMNS; c++)
      begin
        if (s == stage && c == col)
          return want_carry ? carries : heights[c];
        excess = heights[c] + carries - dadda_pkg::stage_target_height(s);
        heights[c] = (excess > 0) ? dadda_pkg::stage_target_height(s) : heights[c] + carries;
        carries = (excess > 0) ? (excess + 1) / 2 : 0;
      end
    end
    return 0;
  endfunction

  // carry_into[c] carries the outputs of column c - 1's adders
  // top entry would weigh 2**32 and is always zero
  logic [COLUMNS:0][SLOTS-1:0] carry_into;

  assign carry_into[0] = '0;

  for (genvar c = 0; c < COLUMNS; c++)
  begin : g_column
    localparam int HEIGHT = column_state(STAGE, c, 1'b0);
    localparam int CARRIES_IN = column_state(STAGE, c, 1'b1);
    localparam int EXCESS = HEIGHT + CARRIES_IN - TARGET;
    // each full adder removes two bits, a half adder only for an odd excess
    localparam int FULL_ADDERS = (EXCESS > 0) ? EXCESS / 2 : 0;
    localparam int HALF_ADDERS = (EXCESS > 0) ? EXCESS % 2 : 0;
    localparam int CONSUMED = 3 * FULL_ADDERS + 2 * HALF_ADDERS;
    localparam int KEPT = HEIGHT - CONSUMED + FULL_ADDERS + HALF_ADDERS;

    logic [SLOTS-1:0] column_bits;
    logic [SLOTS-1:0] carries;

    always_comb
    begin
      logic [2:0] fa_in;
      logic [1:0] ha_in;
      column_bits = '0;
      carries = '0;
      for (int i = 0; i < FULL_ADDERS; i++)
      begin
        fa_in = heap_in[c][3 * i +: 3];
        column_bits[i] = ^fa_in;
        carries[i] = (fa_in[0] & fa_in[1]) | (fa_in[2] & (fa_in[0] ^ fa_in[1]));
      end
      for (int i = 0; i < HALF_ADDERS; i++)
      begin
        ha_in = heap_in[c][3 * FULL_ADDERS + 2 * i +: 2];
        column_bits[FULL_ADDERS + i] = ^ha_in;
        carries[FULL_ADDERS + i] = &ha_in;
      end
      // untouched bits, then the carries arriving from below
      for (int i = 0; i < HEIGHT - CONSUMED; i++)
        column_bits[FULL_ADDERS + HALF_ADDERS + i] = heap_in[c][CONSUMED + i];
      for (int k = 0; k < CARRIES_IN; k++)
        column_bits[KEPT + k] = carry_into[c][k];
    end

    assign heap_out[c] = column_bits;
    assign carry_into[c + 1] = carries;
  end

endmodule

`default_nettype wire

// File: source/dadda_tree.sv
`timescale 1ns/1ns
`default_nettype none

`include "dadda_macros.svh"

module dadda_tree (
  input  wire dadda_pkg::column_heap_t heap,
  output dadda_pkg::product_t          sum_row,
  output dadda_pkg::product_t          carry_row
);

  localparam int STAGES = `DADDA_STAGES;
  localparam int COLUMNS = `DADDA_PRODUCT_WIDTH;

  // heap before and after each stage, heights 16 13 9 6 4 3 2
  dadda_pkg::column_heap_t heaps [0:STAGES];

  assign heaps[0] = heap;

  for (genvar s = 0; s < STAGES; s++)
  begin : g_stage
    dadda_reduction_stage #(
      .STAGE (s)
    ) dadda_reduction_stage_i (
      .heap_in  (heaps[s]),
      .heap_out (heaps[s + 1])
    );
  end

  // two bits left per column
  // a column of height one already has zero in slot one
  for (genvar c = 0; c < COLUMNS; c++)
  begin : g_row
    assign sum_row[c] = heaps[STAGES][c][0];
    assign carry_row[c] = heaps[STAGES][c][1];
  end

endmodule

`default_nettype wire

// File: source/partial_product_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "dadda_macros.svh"

module partial_product_array (
  input  wire dadda_pkg::operand_t a,
  input  wire dadda_pkg::operand_t b,
  output dadda_pkg::column_heap_t  heap
);

  localparam int WIDTH = `DADDA_OPERAND_WIDTH;
  localparam int COLUMNS = `DADDA_PRODUCT_WIDTH;

  // row j holds a gated by b[j]
  logic [WIDTH-1:0][WIDTH-1:0] terms;

  for (genvar j = 0; j < WIDTH; j++)
  begin : g_row
    assign terms[j] = a & {WIDTH{b[j]}};
  end

  // column c collects terms[j][c - j], lowest row first
  for (genvar c = 0; c < COLUMNS; c++)
  begin : g_column
    localparam int FIRST_ROW = (c >= WIDTH) ? c - WIDTH + 1 : 0;

    for (genvar k = 0; k < WIDTH; k++)
    begin : g_slot
      localparam int ROW = FIRST_ROW + k;

      if (k < dadda_pkg::initial_column_height(c))
      begin : g_term
        assign heap[c][k] = terms[ROW][c - ROW];
      end
      else
      begin : g_empty
        assign heap[c][k] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/dadda_multiplier_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dadda_macros.svh"

module dadda_multiplier_tb;

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  dadda_pkg::operand_t a;
  dadda_pkg::operand_t b;
  logic                out_valid;
  dadda_pkg::product_t product;

  // products still owed by the DUT, oldest first
  dadda_pkg::product_t expected_q [$];
  dadda_pkg::product_t expected_head;
  logic                accepted_any;
  logic                seen_result;
  logic [31:0]         lcg_state;
  string               test_name;

  dadda_multiplier dadda_multiplier_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  always #20 clk = ~clk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_mismatch(input dadda_pkg::product_t expected,
                                 input dadda_pkg::product_t actual);
    fail_run($sformatf("Mismatch in %s: expected %h, actual %h", test_name, expected, actual));
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper half of the generator state, the low bits repeat quickly
  function automatic dadda_pkg::operand_t random_operand();
    logic [31:0] value;
    value = next_random();
    return value[31:16];
  endfunction

  task automatic drive_pair(input dadda_pkg::operand_t x, input dadda_pkg::operand_t y);
    dadda_pkg::product_t wide_x;
    dadda_pkg::product_t wide_y;
    wide_x = dadda_pkg::product_t'(x);
    wide_y = dadda_pkg::product_t'(y);
    @(posedge clk);
    in_valid <= 1'b1;
    a <= x;
    b <= y;
    expected_q.push_back(wide_x * wide_y);
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // waits until every owed product has come out and been checked
  task automatic wait_for_results(input int limit);
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 || out_valid)
    begin
      @(posedge clk);
      cycles++;
      if (cycles > limit)
        fail_run($sformatf("Timeout in %s, the result did not arrive", test_name));
    end
  endtask

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      accepted_any <= 1'b0;
      seen_result <= 1'b0;
    end
    else
    begin
      if (in_valid)
        accepted_any <= 1'b1;
      if (out_valid)
        seen_result <= 1'b1;
    end
  end

  // front of the queue moves to expected_head half a cycle before the check
  always @(negedge clk)
  begin
    if (rst_n && out_valid)
    begin
      if (expected_q.size() == 0)
        fail_run("A result arrived with no operand pair outstanding");
      else
        expected_head = expected_q.pop_front();
    end
  end

  a_quiet_until_accept: assert property (@(posedge clk) !accepted_any |-> !out_valid)
    else fail_run("out_valid went high before any operand pair was accepted");

  a_product_matches: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> product == expected_head)
    else report_mismatch($sampled(expected_head), $sampled(product));

  a_result_follows: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> ##`DADDA_LATENCY out_valid)
    else fail_run("A result did not appear two cycles after its operands");

  a_gap_follows: assert property (@(posedge clk) disable iff (!rst_n)
    !in_valid |-> ##`DADDA_LATENCY !out_valid)
    else fail_run("out_valid was high two cycles after an idle input cycle");

  a_product_holds: assert property (@(posedge clk) disable iff (!rst_n)
    seen_result && !out_valid |-> $stable(product))
    else fail_run("product changed while out_valid was low");

  initial
  begin
    clk = 1'b0;
    rst_n = 1'b1;
    in_valid = 1'b0;
    a = '0;
    b = '0;
    lcg_state = 32'h65bf;
    test_name = "reset";
    // a real falling edge so the asynchronous reset fires
    #1 rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    drive_idle(8);

    test_name = "corner";
    for (int i = 0; i < 8; i++)
    begin
      drive_pair('0, random_operand());
      drive_pair(random_operand(), '0);
      drive_pair(16'd1, random_operand());
      drive_pair(random_operand(), 16'd1);
    end
    drive_pair(16'hffff, 16'hffff);
    drive_pair(16'hffff, 16'd1);
    drive_pair(16'h0000, 16'hffff);
    for (int i = 0; i < `DADDA_OPERAND_WIDTH; i++)
    begin
      for (int j = 0; j < `DADDA_OPERAND_WIDTH; j++)
        drive_pair(16'd1 << i, 16'd1 << j);
      drive_pair(16'd1 << i, 16'hffff);
    end
    drive_idle(1);
    wait_for_results(20);

    test_name = "back_to_back";
    repeat (32)
      drive_pair(random_operand(), random_operand());
    drive_idle(1);
    wait_for_results(20);

    test_name = "random";
    repeat (400)
    begin
      drive_pair(random_operand(), random_operand());
      drive_idle(next_random() >> 30);
    end
    drive_idle(1);
    wait_for_results(20);

    // long idle stretch, product must hold the last value
    test_name = "idle";
    drive_pair(16'h1234, 16'h5678);
    drive_idle(12);
    wait_for_results(20);

    if (expected_q.size() == 0)
    begin
      $display("Finished with no errors");
      $finish;
    end
    else
      fail_run("Products were still outstanding at the end of the run");
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
source/dadda_pkg.sv
source/partial_product_array.sv
source/dadda_reduction_stage.sv
source/dadda_tree.sv
source/brent_kung_adder.sv
source/dadda_multiplier.sv
tests/dadda_multiplier_tb.sv
